// ==== bench/tb_exec_cluster.sv ====
`timescale 1ns/100ps

module tb_exec_cluster;

    localparam int LANES       = 2;
    localparam int QUEUE_DEPTH = 8;
    localparam int FULL_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 400;

    localparam int MODE_LOAD  = 0;
    localparam int MODE_ALU   = 1;
    localparam int MODE_SHIFT = 2;
    localparam int MODE_DEP   = 3;
    localparam int MODE_ZERO  = 4;
    localparam int MODE_MIX   = 5;

    logic                aclk;
    logic                aresetn;
    logic                flush;
    logic [LANES-1:0]    in_en;
    exec_pkg::uop_t      in_uop [LANES];
    exec_pkg::reg_addr_t in_rd [LANES];
    exec_pkg::reg_addr_t in_rj [LANES];
    exec_pkg::reg_addr_t in_rk [LANES];
    exec_pkg::word_t     in_imm [LANES];
    logic                full;
    logic [LANES-1:0]    wb_en;
    exec_pkg::reg_addr_t wb_rd [LANES];
    exec_pkg::word_t     wb_data [LANES];

    // spec_regs follows accepted ops, arch_regs follows checked writebacks
    exec_pkg::word_t     spec_regs [32];
    exec_pkg::word_t     arch_regs [32];
    exec_pkg::reg_addr_t exp_rd_q [$];
    exec_pkg::word_t     exp_data_q [$];
    exec_pkg::reg_addr_t recent_rd [4];
    exec_pkg::reg_addr_t prev_wr_rd;
    int                  load_idx;
    int                  value_errors;
    int                  event_errors;
    int                  timeout_errors;
    int                  wb_checked;

    exec_cluster_top #(
        .LANES       (LANES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_exec_cluster_top (
        .aclk    (aclk),
        .aresetn (aresetn),
        .flush   (flush),
        .in_en   (in_en),
        .in_uop  (in_uop),
        .in_rd   (in_rd),
        .in_rj   (in_rj),
        .in_rk   (in_rk),
        .in_imm  (in_imm),
        .full    (full),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    always #10 aclk = ~aclk;

    task automatic compare_addr(input exec_pkg::reg_addr_t got, input exec_pkg::reg_addr_t exp,
                                input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s rd is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_word(input exec_pkg::word_t got, input exec_pkg::word_t exp,
                                input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s data is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic writes_back(input exec_pkg::uop_t uop, input exec_pkg::reg_addr_t rd);
        logic known;
        known = (uop.alu_view.cls == exec_pkg::CLS_ALU) || (uop.alu_view.cls == exec_pkg::CLS_SHIFT);
        return known && (rd != '0);
    endfunction

    function automatic exec_pkg::word_t model_exec(input exec_pkg::uop_t uop,
                                                   input exec_pkg::word_t a,
                                                   input exec_pkg::word_t b);
        exec_pkg::word_t r;
        logic [4:0]      amt;
        r   = '0;
        amt = b[4:0];
        if (uop.alu_view.cls == exec_pkg::CLS_ALU) begin
            case (uop.alu_view.func)
                exec_pkg::FN_ADD:  r = a + b;
                exec_pkg::FN_SUB:  r = a - b;
                exec_pkg::FN_AND:  r = a & b;
                exec_pkg::FN_OR:   r = a | b;
                exec_pkg::FN_XOR:  r = a ^ b;
                exec_pkg::FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                exec_pkg::FN_SLTU: r = (a < b) ? 32'd1 : 32'd0;
                exec_pkg::FN_LUI:  r = b;
                default:           r = '0;
            endcase
        end else if (uop.alu_view.cls == exec_pkg::CLS_SHIFT) begin
            if (uop.shift_view.left) begin
                r = a << amt;
            end else if (uop.shift_view.arith) begin
                r = $signed(a) >>> amt;
            end else begin
                r = a >> amt;
            end
        end
        return r;
    endfunction

    task automatic model_accept(input exec_pkg::uop_t uop, input exec_pkg::reg_addr_t rd,
                                input exec_pkg::reg_addr_t rj, input exec_pkg::reg_addr_t rk,
                                input exec_pkg::word_t imm);
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        exec_pkg::word_t res;
        a = spec_regs[rj];
        b = uop.alu_view.use_imm ? imm : spec_regs[rk];
        if (writes_back(uop, rd)) begin
            res           = model_exec(uop, a, b);
            spec_regs[rd] = res;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
        end
    endtask

    task automatic make_op(input int mode, output exec_pkg::uop_t uop,
                           output exec_pkg::reg_addr_t rd, output exec_pkg::reg_addr_t rj,
                           output exec_pkg::reg_addr_t rk, output exec_pkg::word_t imm);
        int             m;
        exec_pkg::uop_t u;
        m = (mode == MODE_MIX) ? MODE_ALU + int'($urandom % 4) : mode;
        u = '0;
        u.alu_view.use_imm = $urandom % 2;
        imm = $urandom;
        rd  = exec_pkg::reg_addr_t'(1 + $urandom % 31);
        rj  = exec_pkg::reg_addr_t'($urandom % 32);
        rk  = exec_pkg::reg_addr_t'($urandom % 32);
        // small immediates make the compares and shifts interesting
        if ($urandom % 3 == 0) begin
            imm = exec_pkg::word_t'($urandom % 9) - 32'd4;
        end
        case (m)
            MODE_LOAD: begin
                u.alu_view.cls     = exec_pkg::CLS_ALU;
                u.alu_view.func    = exec_pkg::FN_LUI;
                u.alu_view.use_imm = 1'b1;
                imm                = $urandom;
                rd                 = exec_pkg::reg_addr_t'(load_idx);
                load_idx           = (load_idx % 31) + 1;
            end
            MODE_ALU: begin
                u.alu_view.cls  = exec_pkg::CLS_ALU;
                u.alu_view.func = exec_pkg::alu_func_t'(($urandom % 10 < 9) ? $urandom % 8
                                                                          : $urandom % 32);
            end
            MODE_SHIFT: begin
                u.shift_view.cls   = exec_pkg::CLS_SHIFT;
                u.shift_view.left  = $urandom % 2;
                u.shift_view.arith = $urandom % 2;
                u.shift_view.rsvd  = $urandom % 8;
            end
            MODE_DEP: begin
                u.alu_view.cls  = ($urandom % 2) ? exec_pkg::CLS_SHIFT : exec_pkg::CLS_ALU;
                u.alu_view.func = exec_pkg::alu_func_t'($urandom % 8);
                if (u.alu_view.cls == exec_pkg::CLS_SHIFT) begin
                    u.shift_view.left  = $urandom % 2;
                    u.shift_view.arith = $urandom % 2;
                end
                rj = recent_rd[$urandom % 4];
                if ($urandom % 4 != 0) begin
                    rk = recent_rd[$urandom % 4];
                end
            end
            default: begin
                u.alu_view.cls  = exec_pkg::uop_class_t'($urandom % 4);
                u.alu_view.func = exec_pkg::alu_func_t'($urandom % 32);
                if ($urandom % 3 == 0) begin
                    rd = '0;
                end
                if ($urandom % 3 == 0) begin
                    rj = '0;
                end
                if ($urandom % 3 == 0) begin
                    rk = '0;
                end
            end
        endcase
        // adjacent writers get distinct rds, so no dispatch group holds a same-rd pair
        if (writes_back(u, rd) && rd == prev_wr_rd) begin
            rd = rd + 1'b1;
        end
        prev_wr_rd = writes_back(u, rd) ? rd : '0;
        if (writes_back(u, rd)) begin
            recent_rd[3] = recent_rd[2];
            recent_rd[2] = recent_rd[1];
            recent_rd[1] = recent_rd[0];
            recent_rd[0] = rd;
        end
        uop = u;
    endtask

    task automatic check_writebacks();
        exec_pkg::reg_addr_t exp_rd;
        exec_pkg::word_t     exp_data;
        for (int l = 0; l < LANES; l++) begin
            if (wb_en[l] === 1'b1) begin
                if (exp_rd_q.size() == 0) begin
                    event_errors++;
                    $display("unexpected writeback to register %0d on lane %0d at %0t",
                             wb_rd[l], l, $time);
                end else begin
                    exp_rd   = exp_rd_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    compare_addr(wb_rd[l], exp_rd, $sformatf("lane %0d", l));
                    compare_word(wb_data[l], exp_data, $sformatf("lane %0d", l));
                    arch_regs[exp_rd] = exp_data;
                    wb_checked++;
                end
            end
        end
    endtask

    // outputs settle 1 ns after the edge, inputs change 2 ns after it
    task automatic tick();
        @(posedge aclk);
        #1;
        check_writebacks();
        #1;
    endtask

    task automatic run_phase(input int mode, input int cycles, input logic burst);
        int n;
        for (int c = 0; c < cycles; c++) begin
            tick();
            flush = 1'b0;
            n     = burst ? LANES : int'($urandom % (LANES + 1));
            for (int s = 0; s < LANES; s++) begin
                if (!full && s < n) begin
                    make_op(mode, in_uop[s], in_rd[s], in_rj[s], in_rk[s], in_imm[s]);
                    model_accept(in_uop[s], in_rd[s], in_rj[s], in_rk[s], in_imm[s]);
                    in_en[s] = 1'b1;
                end else begin
                    in_en[s] = 1'b0;
                end
            end
        end
    endtask

    task automatic wait_full_low();
        int n;
        n = 0;
        do begin
            tick();
            in_en = '0;
            n++;
        end while (full && n < FULL_LIMIT);
        if (full) begin
            timeout_errors++;
            $display("full stayed high for %0d cycles after the input stopped", FULL_LIMIT);
        end
    endtask

    task automatic apply_flush();
        tick();
        in_en = '0;
        flush = 1'b1;
        for (int r = 0; r < 32; r++) begin
            spec_regs[r] = arch_regs[r];
        end
        exp_rd_q.delete();
        exp_data_q.delete();
        prev_wr_rd = '0;
        tick();
        flush = 1'b0;
    endtask

    task automatic drain_expected();
        int n;
        n = 0;
        do begin
            tick();
            in_en = '0;
            flush = 1'b0;
            n++;
        end while (exp_rd_q.size() != 0 && n < DRAIN_LIMIT);
        if (exp_rd_q.size() != 0) begin
            timeout_errors++;
            $display("%0d expected writebacks never arrived", exp_rd_q.size());
        end
    endtask

    // an idle pipeline dispatches both slots together, so only the younger writes back
    task automatic same_rd_pairs(input int pairs);
        for (int p = 0; p < pairs; p++) begin
            drain_expected();
            repeat (5) tick();
            make_op(MODE_ALU, in_uop[0], in_rd[0], in_rj[0], in_rk[0], in_imm[0]);
            make_op(MODE_ALU, in_uop[1], in_rd[1], in_rj[1], in_rk[1], in_imm[1]);
            if (in_rd[0] == '0) begin
                in_rd[0] = 5'd1;
            end
            in_rd[1] = in_rd[0];
            in_rj[1] = in_rd[0] ^ 5'd1;
            in_rk[1] = in_rd[0] ^ 5'd2;
            model_accept(in_uop[0], in_rd[0], in_rj[0], in_rk[0], in_imm[0]);
            model_accept(in_uop[1], in_rd[1], in_rj[1], in_rk[1], in_imm[1]);
            exp_rd_q.delete(exp_rd_q.size() - 2);
            exp_data_q.delete(exp_data_q.size() - 2);
            in_en = '1;
            tick();
            in_en = '0;
        end
    endtask

    initial begin
        void'($urandom(32'h497b89c4));
        aclk    = 1'b0;
        aresetn = 1'b0;
        flush   = 1'b0;
        in_en   = '0;
        for (int s = 0; s < LANES; s++) begin
            in_uop[s] = '0;
            in_rd[s]  = '0;
            in_rj[s]  = '0;
            in_rk[s]  = '0;
            in_imm[s] = '0;
        end
        for (int r = 0; r < 32; r++) begin
            spec_regs[r] = '0;
            arch_regs[r] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            recent_rd[i] = '0;
        end
        prev_wr_rd     = '0;
        load_idx       = 1;
        value_errors   = 0;
        event_errors   = 0;
        timeout_errors = 0;
        wb_checked     = 0;

        repeat (4) @(posedge aclk);
        #2;
        aresetn = 1'b1;

        run_phase(MODE_LOAD, 20, 1'b1);
        run_phase(MODE_ALU, 300, 1'b0);
        run_phase(MODE_SHIFT, 300, 1'b0);
        run_phase(MODE_DEP, 300, 1'b0);
        run_phase(MODE_ZERO, 200, 1'b0);
        run_phase(MODE_MIX, 150, 1'b1);
        wait_full_low();
        for (int f = 0; f < 3; f++) begin
            run_phase(MODE_MIX, 60, 1'b0);
            apply_flush();
        end
        run_phase(MODE_MIX, 100, 1'b1);
        same_rd_pairs(20);
        drain_expected();
        // idle stretch catches stray writebacks
        repeat (10) tick();

        $display("writebacks checked %0d, value errors %0d, unexpected writebacks %0d, timeouts %0d",
                 wb_checked, value_errors, event_errors, timeout_errors);
        if (value_errors + event_errors + timeout_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== design/exec_cluster_top.sv ====
`timescale 1ns/100ps

module exec_cluster_top #(
    parameter int LANES       = 2,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                flush,
    input  logic [LANES-1:0]    in_en,
    input  exec_pkg::uop_t      in_uop [LANES],
    input  exec_pkg::reg_addr_t in_rd [LANES],
    input  exec_pkg::reg_addr_t in_rj [LANES],
    input  exec_pkg::reg_addr_t in_rk [LANES],
    input  exec_pkg::word_t     in_imm [LANES],
    output logic                full,
    output logic [LANES-1:0]    wb_en,
    output exec_pkg::reg_addr_t wb_rd [LANES],
    output exec_pkg::word_t     wb_data [LANES]
);
    // dispatch
    logic [LANES-1:0]    ds_en;
    exec_pkg::uop_t      ds_uop [LANES];
    exec_pkg::reg_addr_t ds_rd [LANES];
    exec_pkg::reg_addr_t ds_rj [LANES];
    exec_pkg::reg_addr_t ds_rk [LANES];
    exec_pkg::word_t     ds_imm [LANES];

    // operand read
    logic [LANES-1:0]    rf_en;
    exec_pkg::uop_t      rf_uop [LANES];
    exec_pkg::reg_addr_t rf_rd [LANES];
    exec_pkg::word_t     rf_imm [LANES];
    exec_pkg::word_t     rf_data_j [LANES];
    exec_pkg::word_t     rf_data_k [LANES];

    // lane results, one driver per lane
    wire [LANES-1:0]          ex_en;
    wire exec_pkg::reg_addr_t ex_rd [LANES];
    wire exec_pkg::word_t     ex_data [LANES];

    logic [LANES-1:0]    wr_en;
    exec_pkg::reg_addr_t wr_addr [LANES];
    exec_pkg::word_t     wr_data [LANES];

    issue_stage #(
        .LANES       (LANES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_issue_stage (
        .aclk    (aclk),    .aresetn (aresetn), .flush  (flush),
        .in_en   (in_en),   .in_uop  (in_uop),  .in_rd  (in_rd),
        .in_rj   (in_rj),   .in_rk   (in_rk),   .in_imm (in_imm),
        .wr_en   (wr_en),   .wr_addr (wr_addr), .full   (full),
        .ds_en   (ds_en),   .ds_uop  (ds_uop),  .ds_rd  (ds_rd),
        .ds_rj   (ds_rj),   .ds_rk   (ds_rk),   .ds_imm (ds_imm)
    );

    register_file #(
        .LANES (LANES)
    ) u_register_file (
        .aclk      (aclk),      .aresetn   (aresetn),   .flush   (flush),
        .ds_en     (ds_en),     .ds_uop    (ds_uop),    .ds_rd   (ds_rd),
        .ds_rj     (ds_rj),     .ds_rk     (ds_rk),     .ds_imm  (ds_imm),
        .wr_en     (wr_en),     .wr_addr   (wr_addr),   .wr_data (wr_data),
        .rf_en     (rf_en),     .rf_uop    (rf_uop),    .rf_rd   (rf_rd),
        .rf_imm    (rf_imm),    .rf_data_j (rf_data_j), .rf_data_k (rf_data_k)
    );

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        exec_lane u_exec_lane (
            .aclk     (aclk),
            .aresetn  (aresetn),
            .flush    (flush),
            .en       (rf_en[g]),
            .uop      (rf_uop[g]),
            .rd       (rf_rd[g]),
            .imm      (rf_imm[g]),
            .data_j   (rf_data_j[g]),
            .data_k   (rf_data_k[g]),
            .res_en   (ex_en[g]),
            .res_rd   (ex_rd[g]),
            .res_data (ex_data[g])
        );
    end

    writeback_merge #(
        .LANES (LANES)
    ) u_writeback_merge (
        .aclk    (aclk),    .aresetn (aresetn), .flush   (flush),
        .ex_en   (ex_en),   .ex_rd   (ex_rd),   .ex_data (ex_data),
        .wr_en   (wr_en),   .wr_addr (wr_addr), .wr_data (wr_data)
    );

    // debug writeback view of the register write port
    assign wb_en   = wr_en;
    assign wb_rd   = wr_addr;
    assign wb_data = wr_data;

endmodule

// ==== design/exec_lane.sv ====
`timescale 1ns/100ps

module exec_lane (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                flush,
    input  logic                en,
    input  exec_pkg::uop_t      uop,
    input  exec_pkg::reg_addr_t rd,
    input  exec_pkg::word_t     imm,
    input  exec_pkg::word_t     data_j,
    input  exec_pkg::word_t     data_k,
    output logic                res_en,
    output exec_pkg::reg_addr_t res_rd,
    output exec_pkg::word_t     res_data
);
    exec_pkg::word_t op_a;
    exec_pkg::word_t op_b;
    exec_pkg::word_t alu_res;
    exec_pkg::word_t sh_res;
    exec_pkg::word_t result;
    logic [4:0]      shamt;

    assign op_a  = data_j;
    assign op_b  = uop.alu_view.use_imm ? imm : data_k;
    assign shamt = op_b[4:0];

    always_comb begin
        case (uop.alu_view.func)
            exec_pkg::FN_ADD:  alu_res = op_a + op_b;
            exec_pkg::FN_SUB:  alu_res = op_a - op_b;
            exec_pkg::FN_AND:  alu_res = op_a & op_b;
            exec_pkg::FN_OR:   alu_res = op_a | op_b;
            exec_pkg::FN_XOR:  alu_res = op_a ^ op_b;
            exec_pkg::FN_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            exec_pkg::FN_SLTU: alu_res = {31'b0, op_a < op_b};
            exec_pkg::FN_LUI:  alu_res = op_b;
            default:           alu_res = '0;
        endcase
    end

    always_comb begin
        if (uop.shift_view.left) begin
            sh_res = op_a << shamt;
        end else if (uop.shift_view.arith) begin
            sh_res = $signed(op_a) >>> shamt;
        end else begin
            sh_res = op_a >> shamt;
        end
    end

    // reserved classes fall through to zero
    always_comb begin
        case (uop.alu_view.cls)
            exec_pkg::CLS_ALU:   result = alu_res;
            exec_pkg::CLS_SHIFT: result = sh_res;
            default:             result = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || flush) begin
            res_en <= 1'b0;
        end else begin
            res_en <= en && exec_pkg::has_result(uop) && (rd != '0);
        end
    end

    always_ff @(posedge aclk) begin
        res_rd   <= rd;
        res_data <= result;
    end

endmodule

// ==== design/exec_pkg.sv ====
package exec_pkg;

    localparam int REG_W    = 5;
    localparam int WORD_W   = 32;
    localparam int NUM_REGS = 32;

    typedef logic [REG_W-1:0]  reg_addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // classes 2 and 3 are reserved, no writeback
    typedef enum logic [1:0] {
        CLS_ALU   = 2'd0,
        CLS_SHIFT = 2'd1,
        CLS_RSV2  = 2'd2,
        CLS_RSV3  = 2'd3
    } uop_class_t;

    typedef enum logic [4:0] {
        FN_ADD  = 5'd0,
        FN_SUB  = 5'd1,
        FN_AND  = 5'd2,
        FN_OR   = 5'd3,
        FN_XOR  = 5'd4,
        FN_SLT  = 5'd5,
        FN_SLTU = 5'd6,
        FN_LUI  = 5'd7
    } alu_func_t;

    typedef struct packed {
        uop_class_t cls;
        logic       use_imm;
        alu_func_t  func;
    } alu_view_t;

    typedef struct packed {
        uop_class_t cls;
        logic       use_imm;
        logic       left;
        logic       arith;
        logic [2:0] rsvd;
    } shift_view_t;

    // cls and use_imm sit in the same bits in both views
    typedef union packed {
        alu_view_t   alu_view;
        shift_view_t shift_view;
    } uop_t;

    function automatic logic has_result(input uop_t uop);
        return (uop.alu_view.cls == CLS_ALU) || (uop.alu_view.cls == CLS_SHIFT);
    endfunction

endpackage

// ==== design/issue_stage.sv ====
`timescale 1ns/100ps

module issue_stage #(
    parameter int LANES       = 2,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                flush,
    input  logic [LANES-1:0]    in_en,
    input  exec_pkg::uop_t      in_uop [LANES],
    input  exec_pkg::reg_addr_t in_rd [LANES],
    input  exec_pkg::reg_addr_t in_rj [LANES],
    input  exec_pkg::reg_addr_t in_rk [LANES],
    input  exec_pkg::word_t     in_imm [LANES],
    input  logic [LANES-1:0]    wr_en,
    input  exec_pkg::reg_addr_t wr_addr [LANES],
    output logic                full,
    output logic [LANES-1:0]    ds_en,
    output exec_pkg::uop_t      ds_uop [LANES],
    output exec_pkg::reg_addr_t ds_rd [LANES],
    output exec_pkg::reg_addr_t ds_rj [LANES],
    output exec_pkg::reg_addr_t ds_rk [LANES],
    output exec_pkg::word_t     ds_imm [LANES]
);
    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);
    localparam int NR = exec_pkg::NUM_REGS;

    exec_pkg::uop_t      q_uop [QUEUE_DEPTH];
    exec_pkg::reg_addr_t q_rd [QUEUE_DEPTH];
    exec_pkg::reg_addr_t q_rj [QUEUE_DEPTH];
    exec_pkg::reg_addr_t q_rk [QUEUE_DEPTH];
    exec_pkg::word_t     q_imm [QUEUE_DEPTH];

    logic [PW-1:0]    head;
    logic [CW-1:0]    count;
    logic [NR-1:0]    pending;
    logic [NR-1:0]    fl_mask [3];
    logic [LANES-1:0] accept;
    logic [LANES-1:0] issue;
    logic [CW-1:0]    n_accept;
    logic [CW-1:0]    n_issue;
    logic [PW-1:0]    hd_idx [LANES];
    logic [PW-1:0]    tl_idx [LANES];
    logic [NR-1:0]    busy;
    logic [NR-1:0]    set_mask;
    logic [NR-1:0]    clr_mask;
    logic             run;
    logic             hazard;
    exec_pkg::uop_t   hd_uop;

    function automatic logic [PW-1:0] wrap_idx(input int unsigned base, input int unsigned ofs);
        int unsigned sum;
        sum = base + ofs;
        if (sum >= QUEUE_DEPTH) begin
            sum = sum - QUEUE_DEPTH;
        end
        return PW'(sum);
    endfunction

    assign full   = (QUEUE_DEPTH - int'(count)) < LANES;
    assign accept = (full || flush) ? '0 : in_en;

    always_comb begin
        n_accept = '0;
        for (int i = 0; i < LANES; i++) begin
            tl_idx[i] = wrap_idx(head, count + i);
            n_accept  = n_accept + CW'(accept[i]);
        end
    end

    // in-order prefix of ready ops from the head
    always_comb begin
        busy     = pending;
        set_mask = '0;
        issue    = '0;
        n_issue  = '0;
        run      = 1'b1;
        hd_uop   = '0;
        hazard   = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            hd_idx[i] = wrap_idx(head, i);
            hd_uop    = q_uop[hd_idx[i]];
            hazard    = busy[q_rj[hd_idx[i]]] ||
                        (!hd_uop.alu_view.use_imm && busy[q_rk[hd_idx[i]]]);
            if (run && (i < count) && !hazard) begin
                issue[i] = 1'b1;
                n_issue  = n_issue + CW'(1);
                // younger ops in this group see the rd as busy
                if (exec_pkg::has_result(hd_uop) && q_rd[hd_idx[i]] != '0) begin
                    busy[q_rd[hd_idx[i]]]     = 1'b1;
                    set_mask[q_rd[hd_idx[i]]] = 1'b1;
                end
            end else begin
                run = 1'b0;
            end
        end
    end

    always_comb begin
        clr_mask = '0;
        for (int l = 0; l < LANES; l++) begin
            if (wr_en[l]) begin
                clr_mask[wr_addr[l]] = 1'b1;
            end
        end
        // keep the bit while a younger write to it is still in flight
        clr_mask = clr_mask & ~(set_mask | fl_mask[0] | fl_mask[1] | fl_mask[2]);
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || flush) begin
            head    <= '0;
            count   <= '0;
            pending <= '0;
            ds_en   <= '0;
            for (int s = 0; s < 3; s++) begin
                fl_mask[s] <= '0;
            end
        end else begin
            head       <= wrap_idx(head, n_issue);
            count      <= count + n_accept - n_issue;
            pending    <= (pending & ~clr_mask) | set_mask;
            ds_en      <= issue;
            fl_mask[0] <= set_mask;
            fl_mask[1] <= fl_mask[0];
            fl_mask[2] <= fl_mask[1];
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < LANES; i++) begin
            if (accept[i]) begin
                q_uop[tl_idx[i]] <= in_uop[i];
                q_rd[tl_idx[i]]  <= in_rd[i];
                q_rj[tl_idx[i]]  <= in_rj[i];
                q_rk[tl_idx[i]]  <= in_rk[i];
                q_imm[tl_idx[i]] <= in_imm[i];
            end
            ds_uop[i] <= q_uop[hd_idx[i]];
            ds_rd[i]  <= q_rd[hd_idx[i]];
            ds_rj[i]  <= q_rj[hd_idx[i]];
            ds_rk[i]  <= q_rk[hd_idx[i]];
            ds_imm[i] <= q_imm[hd_idx[i]];
        end
    end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/100ps

module register_file #(
    parameter int LANES = 2
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                flush,
    input  logic [LANES-1:0]    ds_en,
    input  exec_pkg::uop_t      ds_uop [LANES],
    input  exec_pkg::reg_addr_t ds_rd [LANES],
    input  exec_pkg::reg_addr_t ds_rj [LANES],
    input  exec_pkg::reg_addr_t ds_rk [LANES],
    input  exec_pkg::word_t     ds_imm [LANES],
    input  logic [LANES-1:0]    wr_en,
    input  exec_pkg::reg_addr_t wr_addr [LANES],
    input  exec_pkg::word_t     wr_data [LANES],
    output logic [LANES-1:0]    rf_en,
    output exec_pkg::uop_t      rf_uop [LANES],
    output exec_pkg::reg_addr_t rf_rd [LANES],
    output exec_pkg::word_t     rf_imm [LANES],
    output exec_pkg::word_t     rf_data_j [LANES],
    output exec_pkg::word_t     rf_data_k [LANES]
);
    exec_pkg::word_t mem [exec_pkg::NUM_REGS];

    // same-cycle write wins over the array, higher lane last
    function automatic exec_pkg::word_t read_port(input exec_pkg::reg_addr_t addr);
        exec_pkg::word_t val;
        val = mem[addr];
        for (int l = 0; l < LANES; l++) begin
            if (wr_en[l] && wr_addr[l] == addr) begin
                val = wr_data[l];
            end
        end
        if (addr == '0) begin
            val = '0;
        end
        return val;
    endfunction

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int r = 0; r < exec_pkg::NUM_REGS; r++) begin
                mem[r] <= '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                if (wr_en[l] && wr_addr[l] != '0) begin
                    mem[wr_addr[l]] <= wr_data[l];
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || flush) begin
            rf_en <= '0;
        end else begin
            rf_en <= ds_en;
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < LANES; i++) begin
            rf_uop[i]    <= ds_uop[i];
            rf_rd[i]     <= ds_rd[i];
            rf_imm[i]    <= ds_imm[i];
            rf_data_j[i] <= read_port(ds_rj[i]);
            rf_data_k[i] <= read_port(ds_rk[i]);
        end
    end

endmodule

// ==== design/writeback_merge.sv ====
`timescale 1ns/100ps

module writeback_merge #(
    parameter int LANES = 2
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                flush,
    input  logic [LANES-1:0]    ex_en,
    input  exec_pkg::reg_addr_t ex_rd [LANES],
    input  exec_pkg::word_t     ex_data [LANES],
    output logic [LANES-1:0]    wr_en,
    output exec_pkg::reg_addr_t wr_addr [LANES],
    output exec_pkg::word_t     wr_data [LANES]
);
    logic [LANES-1:0] keep;

    // older lane loses to a younger lane with the same rd
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            keep[l] = ex_en[l] && (ex_rd[l] != '0);
            for (int m = l + 1; m < LANES; m++) begin
                if (ex_en[m] && ex_rd[m] == ex_rd[l]) begin
                    keep[l] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || flush) begin
            wr_en <= '0;
        end else begin
            wr_en <= keep;
        end
    end

    always_ff @(posedge aclk) begin
        for (int l = 0; l < LANES; l++) begin
            wr_addr[l] <= ex_rd[l];
            wr_data[l] <= ex_data[l];
        end
    end

endmodule

// ==== tb.f ====
design/exec_pkg.sv
design/issue_stage.sv
design/register_file.sv
design/exec_lane.sv
design/writeback_merge.sv
design/exec_cluster_top.sv
bench/tb_exec_cluster.sv
